// File: controlUnit.f
+incdir+testbench
src/ctrlPkg.sv
src/stepCounter.sv
src/instrLatch.sv
src/ctrlWordGen.sv
src/controlUnit.sv
testbench/controlUnitTb.sv

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
    parameter int numSteps = 8
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  ctrlPkg::instr_u      irWord,
    input  ctrlPkg::aluFlags_t   flags,
    output ctrlPkg::ctrlWord_t   ctrl,
    output logic [numSteps-1:0]  step
);
    import ctrlPkg::*;

    decInstr_t instr;
    logic      done;   // Last step of the instruction

    stepCounter #(
        .numSteps(numSteps)
    ) uStepCounter (
        .Clock (Clock),
        .rstN  (rstN),
        .done  (done),
        .step  (step)
    );

    instrLatch #(
        .numSteps(numSteps)
    ) uInstrLatch (
        .Clock  (Clock),
        .rstN   (rstN),
        .step   (step),
        .irWord (irWord),
        .instr  (instr)
    );

    ctrlWordGen #(
        .numSteps(numSteps)
    ) uCtrlWordGen (
        .step  (step),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl),
        .done  (done)
    );

endmodule

// File: src/ctrlPkg.sv
package ctrlPkg;

    ////////////////////////////////////////////////////////////
    // Instruction word, decoded two ways

    typedef struct packed {
        logic [5:0] opcode;
        logic       sFlag;    // Write flags
        logic       dstHigh;  // Set for general file
        logic [1:0] dstLow;
        logic [2:0] sreg1;
        logic [2:0] sreg2;
    } regForm_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [1:0] rsel;
        logic [7:0] address;  // Branch offset
    } addrForm_t;

    typedef union packed {
        regForm_t  regForm;   // ALU and inc/dec
        addrForm_t addrForm;  // Branches
    } instr_u;

    // Bit 2 picks the general file
    typedef logic [2:0] dst_t;

    typedef enum logic [2:0] {
        ClsNop,
        ClsBranch,
        ClsIncDec,
        ClsUnary,
        ClsBinary
    } instrClass_e;

    typedef enum logic [4:0] {
        PassA = 5'b10000,
        Not   = 5'b10010,
        Add   = 5'b10100,
        AddC  = 5'b10101,
        Sub   = 5'b10110,
        And   = 5'b10111,
        Or    = 5'b11000,
        Xor   = 5'b11001,
        Nand  = 5'b11010,
        Lsl   = 5'b11011,
        Lsr   = 5'b11100,
        Asr   = 5'b11101,
        Csl   = 5'b11110,
        Csr   = 5'b11111
    } aluOp_e;

    // Same codes in both register files
    typedef enum logic [2:0] {
        Dec   = 3'b000,
        Inc   = 3'b001,
        Load  = 3'b010,
        Clear = 3'b011
    } regFun_e;

    typedef enum logic [1:0] {
        MuxAAluOut = 2'b00,
        MuxAOutC   = 2'b01,
        MuxAIrOut  = 2'b11
    } muxASrc_e;

    typedef enum logic [1:0] {
        MuxBAluOut = 2'b00,
        MuxBOutC   = 2'b01
    } muxBSrc_e;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic o;
    } aluFlags_t;

    ////////////////////////////////////////////////////////////
    // Datapath control word

    typedef struct packed {
        regFun_e    arfFunSel;
        logic [2:0] arfRegSel;   // Active low enables
        logic [1:0] arfOutCSel;
        logic [1:0] arfOutDSel;
        regFun_e    rfFunSel;
        logic [3:0] rfRegSel;    // Active low enables
        logic [3:0] rfScrSel;
        logic [2:0] rfOutASel;
        logic [2:0] rfOutBSel;
        aluOp_e     aluFunSel;
        logic       aluWf;
        muxASrc_e   muxASel;
        muxBSrc_e   muxBSel;
        logic       memCs;       // Active low
        logic       memWr;
        logic       irLh;
        logic       irWrite;
    } ctrlWord_t;

    typedef struct packed {
        instrClass_e cls;
        aluOp_e      aluOp;
        logic        isDec;
        logic        wantZ;      // Z value that takes the branch
        logic        needZ;      // Branch depends on Z
        logic        writeFlags;
        dst_t        dst;
        logic [2:0]  sreg1;
        logic [2:0]  sreg2;
        logic [5:0]  opcode;
    } decInstr_t;

    localparam ctrlWord_t CtrlIdle = '{
        arfFunSel:  Dec,
        arfRegSel:  3'b111,
        arfOutCSel: 2'b00,
        arfOutDSel: 2'b00,
        rfFunSel:   Dec,
        rfRegSel:   4'b1111,
        rfScrSel:   4'b1111,
        rfOutASel:  3'b000,
        rfOutBSel:  3'b000,
        aluFunSel:  aluOp_e'(5'b00000),
        aluWf:      1'b0,
        muxASel:    MuxAAluOut,
        muxBSel:    MuxBAluOut,
        memCs:      1'b1,
        memWr:      1'b0,
        irLh:       1'b0,
        irWrite:    1'b0
    };

    localparam logic [2:0] SelS1 = 3'b100;  // Scratch outputs
    localparam logic [2:0] SelS2 = 3'b101;
    localparam logic [3:0] ScrS1 = 4'b0111;
    localparam logic [3:0] ScrS2 = 4'b1011;
    localparam logic [2:0] ArfSelPc = 3'b011;
    localparam logic [2:0] ArfSelSp = 3'b110;
    localparam logic [2:0] ArfSelAr = 3'b101;

    localparam logic [5:0] OpBra = 6'd0;
    localparam logic [5:0] OpInc = 6'd5;
    localparam logic [5:0] OpDec = 6'd6;
    localparam logic [5:0] OpMov = 6'd24;   // Pass with flag write

    localparam int StepFetchLo = 0;
    localparam int StepFetchHi = 1;
    localparam int StepDecode  = 2;
    localparam int StepExec3   = 3;
    localparam int StepExec4   = 4;
    localparam int StepExec5   = 5;

endpackage

// File: src/ctrlWordGen.sv
`timescale 1ns/1ps

module ctrlWordGen #(
    parameter int numSteps = 8
) (
    input  logic [numSteps-1:0]  step,
    input  ctrlPkg::decInstr_t   instr,
    input  ctrlPkg::aluFlags_t   flags,
    output ctrlPkg::ctrlWord_t   ctrl,
    output logic                 done
);
    import ctrlPkg::*;

    logic taken;

    ////////////////////////////////////////////////////////////
    // Select encodings

    // Register code to OutC select
    function automatic logic [1:0] arfOutCode(input logic [1:0] code);
        case (code)
            2'b10:   return 2'b11;  // SP
            2'b11:   return 2'b10;  // AR
            default: return 2'b00;  // PC for 00 and 01
        endcase
    endfunction

    function automatic logic [3:0] rfDstSel(input logic [1:0] code);
        case (code)
            2'b00:   return 4'b0111;  // R1
            2'b01:   return 4'b1011;  // R2
            2'b10:   return 4'b1101;  // R3
            default: return 4'b1110;  // R4
        endcase
    endfunction

    function automatic logic [2:0] arfDstSel(input logic [1:0] code);
        case (code)
            2'b10:   return ArfSelSp;
            2'b11:   return ArfSelAr;
            default: return ArfSelPc;
        endcase
    endfunction

    // General register direct, address register through scratch
    function automatic logic [2:0] outSel(input logic [2:0] sreg, input logic [2:0] scrSel);
        return sreg[2] ? {1'b0, sreg[1:0]} : scrSel;
    endfunction

    ////////////////////////////////////////////////////////////
    // Step actions

    // Copy an address register into a scratch register
    function automatic ctrlWord_t loadScratch(
        input ctrlWord_t  c,
        input logic [2:0] sreg,
        input logic [3:0] scr
    );
        if (!sreg[2])
        begin
            c.arfOutCSel = arfOutCode(sreg[1:0]);
            c.muxASel    = MuxAOutC;
            c.rfFunSel   = Load;
            c.rfScrSel   = scr;
        end
        return c;
    endfunction

    function automatic ctrlWord_t destWrite(
        input ctrlWord_t c,
        input decInstr_t d,
        input aluOp_e    op
    );
        c.aluFunSel = op;
        c.rfOutASel = outSel(d.sreg1, SelS1);
        c.rfOutBSel = outSel(d.sreg2, SelS2);
        c.aluWf     = d.writeFlags;
        if (d.dst[2])
        begin
            c.muxASel  = MuxAAluOut;
            c.rfFunSel = Load;
            c.rfRegSel = rfDstSel(d.dst[1:0]);
        end
        else
        begin
            c.muxBSel   = MuxBAluOut;
            c.arfFunSel = Load;
            c.arfRegSel = arfDstSel(d.dst[1:0]);
        end
        return c;
    endfunction

    // Count the copied value in place
    function automatic ctrlWord_t destStep(input ctrlWord_t c, input decInstr_t d);
        regFun_e fun;
        fun = d.isDec ? Dec : Inc;
        if (d.dst[2])
        begin
            c.rfFunSel = fun;
            c.rfRegSel = rfDstSel(d.dst[1:0]);
        end
        else
        begin
            c.arfFunSel = fun;
            c.arfRegSel = arfDstSel(d.dst[1:0]);
        end
        return c;
    endfunction

    assign taken = !instr.needZ || (flags.z == instr.wantZ);

    ////////////////////////////////////////////////////////////
    // Control word per step

    always_comb
    begin
        ctrl = CtrlIdle;
        done = 1'b0;
        if (step[StepFetchLo] || step[StepFetchHi])
        begin
            ctrl.memCs      = 1'b0;
            ctrl.arfOutDSel = 2'b01;          // PC to memory address
            ctrl.arfRegSel  = ArfSelPc;
            ctrl.arfFunSel  = Inc;
            ctrl.irWrite    = 1'b1;
            ctrl.irLh       = step[StepFetchHi];  // High byte second
        end
        else if (step[StepExec3])
        begin
            case (instr.cls)
                ClsBranch:
                begin
                    if (taken)
                        ctrl = loadScratch(ctrl, 3'b000, ScrS1);  // S1 <- PC
                    else
                        done = 1'b1;
                end
                ClsIncDec, ClsUnary, ClsBinary:
                    ctrl = loadScratch(ctrl, instr.sreg1, ScrS1);
                default:
                    done = 1'b1;
            endcase
        end
        else if (step[StepExec4])
        begin
            case (instr.cls)
                ClsBranch:
                begin
                    ctrl.muxASel  = MuxAIrOut;    // S2 <- offset
                    ctrl.rfFunSel = Load;
                    ctrl.rfScrSel = ScrS2;
                end
                ClsBinary:
                    ctrl = loadScratch(ctrl, instr.sreg2, ScrS2);
                ClsUnary:
                begin
                    ctrl = destWrite(ctrl, instr, instr.aluOp);
                    done = 1'b1;
                end
                ClsIncDec:
                    ctrl = destWrite(ctrl, instr, PassA);  // Copy source first
                default:
                    ctrl = CtrlIdle;
            endcase
        end
        else if (step[StepExec5])
        begin
            case (instr.cls)
                ClsBranch:
                begin
                    ctrl.rfOutASel = SelS1;
                    ctrl.rfOutBSel = SelS2;
                    ctrl.aluFunSel = Add;         // PC plus offset
                    ctrl.muxBSel   = MuxBAluOut;
                    ctrl.arfRegSel = ArfSelPc;
                    ctrl.arfFunSel = Load;
                    done           = 1'b1;
                end
                ClsBinary:
                begin
                    ctrl = destWrite(ctrl, instr, instr.aluOp);
                    done = 1'b1;
                end
                ClsIncDec:
                begin
                    ctrl = destStep(ctrl, instr);
                    done = 1'b1;
                end
                default:
                    ctrl = CtrlIdle;
            endcase
        end
    end

    // Fetch and decode always run to T3
    assert property (@(step)
        (done === 1'b1) |-> (step[StepDecode:StepFetchLo] === 3'b000))
        else $error("done raised before T3");

endmodule

// File: src/instrLatch.sv
`timescale 1ns/1ps

module instrLatch #(
    parameter int numSteps = 8
) (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic [numSteps-1:0]   step,
    input  ctrlPkg::instr_u       irWord,
    output ctrlPkg::decInstr_t    instr
);
    import ctrlPkg::*;

    decInstr_t   decoded;
    decInstr_t   held;
    instrClass_e clsQ;

    ////////////////////////////////////////////////////////////
    // Opcode decode

    always_comb
    begin
        decoded            = '0;
        decoded.cls        = ClsNop;
        decoded.aluOp      = PassA;
        decoded.opcode     = irWord.regForm.opcode;
        decoded.dst        = {irWord.regForm.dstHigh, irWord.regForm.dstLow};
        decoded.sreg1      = irWord.regForm.sreg1;
        decoded.sreg2      = irWord.regForm.sreg2;
        decoded.isDec      = (irWord.regForm.opcode == OpDec);
        // Opcode 1 wants Z clear, opcode 2 wants Z set
        decoded.needZ      = |irWord.addrForm.opcode[1:0];
        decoded.wantZ      = irWord.addrForm.opcode[1];

        case (irWord.regForm.opcode)
            6'd0, 6'd1, 6'd2: decoded.cls = ClsBranch;
            OpInc, OpDec:     decoded.cls = ClsIncDec;
            6'd7:  begin decoded.cls = ClsUnary;  decoded.aluOp = Lsl;  end
            6'd8:  begin decoded.cls = ClsUnary;  decoded.aluOp = Lsr;  end
            6'd9:  begin decoded.cls = ClsUnary;  decoded.aluOp = Asr;  end
            6'd10: begin decoded.cls = ClsUnary;  decoded.aluOp = Csl;  end
            6'd11: begin decoded.cls = ClsUnary;  decoded.aluOp = Csr;  end
            6'd14: begin decoded.cls = ClsUnary;  decoded.aluOp = Not;  end
            OpMov: begin decoded.cls = ClsUnary;  decoded.aluOp = PassA; end
            6'd12, 6'd27: begin decoded.cls = ClsBinary; decoded.aluOp = And;  end
            6'd13, 6'd28: begin decoded.cls = ClsBinary; decoded.aluOp = Or;   end
            6'd15, 6'd29: begin decoded.cls = ClsBinary; decoded.aluOp = Xor;  end
            6'd16: begin decoded.cls = ClsBinary; decoded.aluOp = Nand; end
            6'd21, 6'd25: begin decoded.cls = ClsBinary; decoded.aluOp = Add;  end
            6'd22: begin decoded.cls = ClsBinary; decoded.aluOp = AddC; end
            6'd23, 6'd26: begin decoded.cls = ClsBinary; decoded.aluOp = Sub;  end
            default: decoded.cls = ClsNop;  // Dropped opcodes
        endcase

        // 24 to 29 always write flags, the rest follow sFlag
        decoded.writeFlags = (irWord.regForm.opcode >= OpMov && irWord.regForm.opcode <= 6'd29)
            || ((decoded.cls inside {ClsUnary, ClsBinary}) && irWord.regForm.sFlag);
    end

    ////////////////////////////////////////////////////////////
    // Capture on the edge that ends T2

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
            clsQ <= ClsNop;
        else if (step[StepDecode])
            clsQ <= decoded.cls;
    end

    always_ff @(posedge Clock)
    begin
        if (step[StepDecode])
            held <= decoded;
    end

    always_comb
    begin
        instr     = held;
        instr.cls = clsQ;
    end

    assert property (@(posedge Clock) disable iff (!rstN)
        (clsQ inside {ClsUnary, ClsBinary} && held.aluOp == PassA) |-> held.opcode == OpMov)
        else $error("ALU instruction latched with PassA");

endmodule

// File: src/stepCounter.sv
`timescale 1ns/1ps

module stepCounter #(
    parameter int numSteps = 8
) (
    input  logic                Clock,
    input  logic                rstN,
    input  logic                done,
    output logic [numSteps-1:0] step
);
    import ctrlPkg::*;

    localparam logic [numSteps-1:0] FirstStep = numSteps'(1) << StepFetchLo;

    logic [numSteps-1:0] stepQ;

    // Execute steps need T0 to T5
    if (numSteps < StepExec5 + 1)
    begin : gWidthCheck
        $error("stepCounter needs at least six steps");
    end

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            stepQ <= FirstStep;
        end
        else if (done)
        begin
            stepQ <= FirstStep;             // Next instruction
        end
        else
        begin
            stepQ <= stepQ << 1;
        end
    end

    assign step = stepQ;

    ////////////////////////////////////////////////////////////
    // Checks

    // Shifting never loses the token
    assert property (@(posedge Clock) disable iff (!rstN) $onehot(stepQ))
        else $error("step is not one-hot");

    // Generator must end every instruction before the top step
    assert property (@(posedge Clock) disable iff (!rstN) stepQ[numSteps-1] |-> done)
        else $error("step ran past the last step");

endmodule

// File: testbench/ctrlRefModel.svh
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Opcode map

function automatic instrClass_e classOf(input logic [5:0] op);
    if (op <= 6'd2)
        return ClsBranch;
    if (op == 6'd5 || op == 6'd6)
        return ClsIncDec;
    if ((op >= 6'd7 && op <= 6'd11) || op == 6'd14 || op == 6'd24)
        return ClsUnary;
    if (op inside {[6'd12:6'd13], [6'd15:6'd16], [6'd21:6'd23], [6'd25:6'd29]})
        return ClsBinary;
    return ClsNop;                      // Dropped and unused opcodes
endfunction

function automatic aluOp_e aluOpOf(input logic [5:0] op);
    case (op)
        6'd7:          return Lsl;
        6'd8:          return Lsr;
        6'd9:          return Asr;
        6'd10:         return Csl;
        6'd11:         return Csr;
        6'd14:         return Not;
        6'd12, 6'd27:  return And;
        6'd13, 6'd28:  return Or;
        6'd15, 6'd29:  return Xor;
        6'd16:         return Nand;
        6'd21, 6'd25:  return Add;
        6'd22:         return AddC;
        6'd23, 6'd26:  return Sub;
        default:       return PassA;    // Opcode 24
    endcase
endfunction

function automatic logic branchTaken(input logic [5:0] op, input aluFlags_t f);
    case (op)
        6'd0:    return 1'b1;           // Unconditional
        6'd1:    return !f.z;
        6'd2:    return f.z;
        default: return 1'b0;
    endcase
endfunction

////////////////////////////////////////////////////////////
// Select encodings

function automatic logic [1:0] addrOutCSel(input logic [1:0] code);
    if (code == 2'b10)
        return 2'b11;                   // SP
    if (code == 2'b11)
        return 2'b10;                   // AR
    return 2'b00;                       // PC
endfunction

function automatic logic [2:0] addrRegSel(input logic [1:0] code);
    if (code == 2'b10)
        return 3'b110;
    if (code == 2'b11)
        return 3'b101;
    return 3'b011;
endfunction

function automatic logic [2:0] sourceSel(input logic [2:0] sreg, input logic [2:0] scratch);
    if (sreg[2])
        return {1'b0, sreg[1:0]};       // General register read directly
    return scratch;
endfunction

function automatic ctrlWord_t copyToScratch(
    input ctrlWord_t  c,
    input logic [2:0] sreg,
    input logic [3:0] scr
);
    if (!sreg[2])
    begin
        c.arfOutCSel = addrOutCSel(sreg[1:0]);
        c.muxASel    = MuxAOutC;
        c.rfFunSel   = Load;
        c.rfScrSel   = scr;
    end
    return c;
endfunction

function automatic ctrlWord_t writeResult(
    input ctrlWord_t c,
    input instr_u    w,
    input aluOp_e    op,
    input logic      wf
);
    c.aluFunSel = op;
    c.aluWf     = wf;
    c.rfOutASel = sourceSel(w.regForm.sreg1, SelS1);
    c.rfOutBSel = sourceSel(w.regForm.sreg2, SelS2);
    if (w.regForm.dstHigh)
    begin
        c.muxASel  = MuxAAluOut;
        c.rfFunSel = Load;
        c.rfRegSel = ~(4'b1000 >> w.regForm.dstLow);  // R1 is the top bit
    end
    else
    begin
        c.muxBSel   = MuxBAluOut;
        c.arfFunSel = Load;
        c.arfRegSel = addrRegSel(w.regForm.dstLow);
    end
    return c;
endfunction

function automatic ctrlWord_t countResult(input ctrlWord_t c, input instr_u w);
    regFun_e fun;
    fun = (w.regForm.opcode == 6'd6) ? Dec : Inc;
    if (w.regForm.dstHigh)
    begin
        c.rfFunSel = fun;
        c.rfRegSel = ~(4'b1000 >> w.regForm.dstLow);
    end
    else
    begin
        c.arfFunSel = fun;
        c.arfRegSel = addrRegSel(w.regForm.dstLow);
    end
    return c;
endfunction

////////////////////////////////////////////////////////////
// Expected results

function automatic int expectedLength(input instr_u w, input aluFlags_t f);
    case (classOf(w.regForm.opcode))
        ClsUnary:            return 5;
        ClsBinary, ClsIncDec: return 6;
        ClsBranch:           return branchTaken(w.addrForm.opcode, f) ? 6 : 4;
        default:             return 4;
    endcase
endfunction

function automatic ctrlWord_t expectedCtrl(input instr_u w, input aluFlags_t f, input int idx);
    ctrlWord_t   c;
    instrClass_e cls;
    logic [5:0]  op;
    logic        wf;
    c   = CtrlIdle;
    op  = w.regForm.opcode;
    cls = classOf(op);
    wf  = (cls inside {ClsUnary, ClsBinary})
        && (w.regForm.sFlag || (op >= 6'd24 && op <= 6'd29));
    case (idx)
        StepFetchLo, StepFetchHi:
        begin
            c.memCs      = 1'b0;
            c.arfOutDSel = 2'b01;
            c.arfRegSel  = 3'b011;
            c.arfFunSel  = Inc;
            c.irWrite    = 1'b1;
            c.irLh       = (idx == StepFetchHi);
        end
        StepExec3:
        begin
            if (cls == ClsBranch)
            begin
                if (branchTaken(op, f))
                    c = copyToScratch(c, 3'b000, ScrS1);  // Current PC
            end
            else if (cls != ClsNop)
                c = copyToScratch(c, w.regForm.sreg1, ScrS1);
        end
        StepExec4:
        begin
            case (cls)
                ClsBranch:
                begin
                    c.muxASel  = MuxAIrOut;
                    c.rfFunSel = Load;
                    c.rfScrSel = ScrS2;
                end
                ClsBinary: c = copyToScratch(c, w.regForm.sreg2, ScrS2);
                ClsUnary:  c = writeResult(c, w, aluOpOf(op), wf);
                ClsIncDec: c = writeResult(c, w, PassA, 1'b0);
                default:   c = CtrlIdle;
            endcase
        end
        StepExec5:
        begin
            case (cls)
                ClsBranch:
                begin
                    c.rfOutASel = SelS1;
                    c.rfOutBSel = SelS2;
                    c.aluFunSel = Add;
                    c.muxBSel   = MuxBAluOut;
                    c.arfRegSel = 3'b011;
                    c.arfFunSel = Load;
                end
                ClsBinary: c = writeResult(c, w, aluOpOf(op), wf);
                ClsIncDec: c = countResult(c, w);
                default:   c = CtrlIdle;
            endcase
        end
        default: c = CtrlIdle;          // Decode step
    endcase
    return c;
endfunction

`endif

// File: testbench/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;
    import ctrlPkg::*;

    localparam int NumSteps    = 8;
    localparam int ClockPeriod = 20;
    localparam int NumRandom   = 300;
    localparam int NumInstr    = 19 * 16 + 16 + 6 + 40 + NumRandom;

    logic                Clock;
    logic                rstN;
    instr_u              irWord;
    aluFlags_t           flags;
    ctrlWord_t           ctrl;
    logic [NumSteps-1:0] step;

    logic [31:0] lcgState;
    ctrlWord_t   expCtrl;
    int          stepIdx;   // Step the DUT should be in

    `include "ctrlRefModel.svh"

    controlUnit #(
        .numSteps(NumSteps)
    ) DUT (
        .Clock  (Clock),
        .rstN   (rstN),
        .irWord (irWord),
        .flags  (flags),
        .ctrl   (ctrl),
        .step   (step)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic checkCtrl(input ctrlWord_t got, input ctrlWord_t exp, input int idx);
        if (got !== exp)
        begin
            $display("mismatch at %0t: control word at T%0d of opcode %0d, got %h, expected %h",
                $time, idx, irWord.regForm.opcode, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped on the first error");
        end
    endtask

    task automatic checkStep(input logic [NumSteps-1:0] got, input int idx);
        logic [NumSteps-1:0] exp;
        exp = NumSteps'(1) << idx;
        if (got !== exp)
        begin
            $display("mismatch at %0t: step of opcode %0d, got %b, expected %b",
                $time, irWord.regForm.opcode, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped on the first error");
        end
    endtask

    always @(posedge Clock)
    begin
        if (rstN)
        begin
            expCtrl = expectedCtrl(irWord, flags, stepIdx);
            checkStep(step, stepIdx);
            checkCtrl(ctrl, expCtrl, stepIdx);
            if (stepIdx + 1 >= expectedLength(irWord, flags))
                stepIdx = 0;                // Back to T0 next cycle
            else
                stepIdx++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    // Called 2 ns after the edge that starts T0
    task automatic runInstr(input instr_u w, input aluFlags_t f);
        int len;
        irWord = w;
        flags  = f;
        len = expectedLength(w, f);
        repeat (len) @(posedge Clock);
        #2;
    endtask

    task automatic runAluOps();
        instr_u      w;
        logic [31:0] r;
        for (int op = 0; op < 64; op++)
            if (classOf(6'(op)) inside {ClsUnary, ClsBinary})
                for (int dst = 0; dst < 8; dst++)
                    for (int s = 0; s < 2; s++)
                    begin
                        r = nextRandom();
                        w.regForm.opcode  = 6'(op);
                        w.regForm.sFlag   = s[0];
                        w.regForm.dstHigh = dst[2];
                        w.regForm.dstLow  = dst[1:0];
                        w.regForm.sreg1   = r[18:16];  // Either file
                        w.regForm.sreg2   = r[22:20];
                        runInstr(w, r[27:24]);
                    end
    endtask

    task automatic runIncDec();
        instr_u      w;
        logic [31:0] r;
        for (int op = 5; op < 7; op++)
            for (int dst = 0; dst < 8; dst++)
            begin
                r = nextRandom();
                w.regForm.opcode  = 6'(op);
                w.regForm.sFlag   = r[16];          // No effect on aluWf
                w.regForm.dstHigh = dst[2];
                w.regForm.dstLow  = dst[1:0];
                w.regForm.sreg1   = 3'(7 - dst);
                w.regForm.sreg2   = r[22:20];
                runInstr(w, r[27:24]);
            end
    endtask

    task automatic runBranches();
        instr_u      w;
        aluFlags_t   f;
        logic [31:0] r;
        for (int op = 0; op < 3; op++)
            for (int z = 0; z < 2; z++)
            begin
                r = nextRandom();
                w                  = '0;
                w.addrForm.opcode  = 6'(op);
                w.addrForm.rsel    = r[17:16];
                w.addrForm.address = r[31:24];
                f                  = r[23:20];
                f.z                = z[0];
                runInstr(w, f);
            end
    endtask

    task automatic runDropped();
        instr_u      w;
        logic [31:0] r;
        for (int op = 0; op < 64; op++)
            if (classOf(6'(op)) == ClsNop)
            begin
                r = nextRandom();
                w = r[31:16];
                w.regForm.opcode = 6'(op);
                runInstr(w, r[15:12]);
            end
    endtask

    // Back to back stream, about half of it no-ops
    task automatic runRandom(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++)
        begin
            r = nextRandom();
            runInstr(r[31:16], r[15:12]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog

    initial
    begin
        #((NumInstr * 6 + 20) * ClockPeriod);
        $display("Watchdog expired at %0t, the run did not finish", $time);
        $display("RESULT: FAIL");
        $fatal(1, "Timeout");
    end

    initial
    begin
        Clock    = 1'b0;
        rstN     = 1'b0;
        irWord   = '0;
        flags    = '0;
        lcgState = 32'h0d9c_3f3d;
        stepIdx  = 0;
        repeat (2) @(posedge Clock);
        #2;
        rstN = 1'b1;
        runAluOps();
        runIncDec();
        runBranches();
        runDropped();
        runRandom(NumRandom);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
